//--- src/cpu_defines.svh
// Core-wide sizes, vectors and physical register indices.
// Included by the RTL and the testbench wherever a constant is needed.

`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// ----------------------------------------------------------------------
// Register file sizing.
// ----------------------------------------------------------------------

`define PHY_REGS        46
`define PHY_IDX_W       6

// ----------------------------------------------------------------------
// Reset state and fetch.
// ----------------------------------------------------------------------

`define RESET_VECTOR    32'h0000_0000
// Supervisor mode with IRQ and FIQ masked.
`define CPSR_INIT       32'h0000_00D3
`define PC_STEP         32'd4

// Exception vectors.
`define DABT_VECTOR     32'h0000_0010
`define FIQ_VECTOR      32'h0000_001C
`define IRQ_VECTOR      32'h0000_0018
`define PABT_VECTOR     32'h0000_000C
`define SWI_VECTOR      32'h0000_0008
`define UND_VECTOR      32'h0000_0004

// ----------------------------------------------------------------------
// Physical register indices.
// ----------------------------------------------------------------------

`define ARCH_PC         6'd15
`define PHY_RAZ_REG     6'd45

// Banked copies of R14 and the SPSR, one pair per exception mode.
`define PHY_FIQ_R14     6'd16
`define PHY_FIQ_SPSR    6'd17
`define PHY_IRQ_R14     6'd18
`define PHY_IRQ_SPSR    6'd19
`define PHY_SVC_R14     6'd20
`define PHY_SVC_SPSR    6'd21
`define PHY_ABT_R14     6'd22
`define PHY_ABT_SPSR    6'd23
`define PHY_UND_R14     6'd24
`define PHY_UND_SPSR    6'd25

`endif

//--- src/cpu_arch_pkg.sv
// Architectural types of the core: processor modes and the CPSR word.
// Imported by logic that reads or updates the status register.

package cpu_arch_pkg;

        // ----------------------------------------------------------------------
        // Processor modes, as held in CPSR[4:0].
        // ----------------------------------------------------------------------

        typedef enum logic [4:0] {
                MODE_USR = 5'b10000,
                MODE_FIQ = 5'b10001,
                MODE_IRQ = 5'b10010,
                MODE_SVC = 5'b10011,
                MODE_ABT = 5'b10111,
                MODE_UND = 5'b11011,
                MODE_SYS = 5'b11111
        } cpu_mode_e;

        // Field layout of the CPSR.
        typedef struct packed {
                logic           n;
                logic           z;
                logic           c;
                logic           v;
                logic [19:0]    rsvd;
                logic           i;
                logic           f;
                logic           t;      // Always zero, no 16-bit state.
                cpu_mode_e      mode;
        } cpsr_fields_t;

        // The same word seen whole, for SPSR saves and reset, or by field.
        typedef union packed {
                logic [31:0]    raw;
                cpsr_fields_t   fld;
        } cpsr_t;

endpackage

//--- src/reg_map_pkg.sv
// Register file and retirement types shared by the writeback logic
// and the testbench.

`include "cpu_defines.svh"

package reg_map_pkg;

        // Index into the physical register file.
        typedef logic [`PHY_IDX_W-1:0] phy_idx_t;

        // ----------------------------------------------------------------------
        // Action taken by the commit logic in a cycle.
        // ----------------------------------------------------------------------

        // Exceptions listed highest priority first.
        typedef enum logic [2:0] {
                RET_NONE,
                RET_DABT,
                RET_FIQ,
                RET_IRQ,
                RET_PABT,
                RET_SWI,
                RET_UND,
                RET_RETIRE
        } retire_kind_e;

endpackage

//--- src/reg_file.sv
// Banked physical register file, two write ports and two
// combinational read ports.

`timescale 1ns/10ps

`include "cpu_defines.svh"

module reg_file
        import reg_map_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_reset,

        input  logic            i_wen,
        input  phy_idx_t        i_wr_idx_a,
        input  phy_idx_t        i_wr_idx_b,
        input  logic [31:0]     i_wr_data_a,
        input  logic [31:0]     i_wr_data_b,

        input  phy_idx_t        i_rd_idx_0,
        input  phy_idx_t        i_rd_idx_1,
        output logic [31:0]     o_rd_data_0,
        output logic [31:0]     o_rd_data_1
);

logic [31:0] regs [`PHY_REGS];

// True for an index that maps onto real storage.
function automatic logic idx_live(input phy_idx_t idx);
        return (idx != `PHY_RAZ_REG) && (idx < `PHY_REGS);
endfunction

// ----------------------------------------------------------------------
// Write ports.
// ----------------------------------------------------------------------

// Port B is written last so it wins on a shared index.
always_ff @(posedge i_clk)
begin
        if (!i_reset && i_wen)
        begin
                if (idx_live(i_wr_idx_a))
                        regs[i_wr_idx_a] <= i_wr_data_a;
                if (idx_live(i_wr_idx_b))
                        regs[i_wr_idx_b] <= i_wr_data_b;
        end
end

// ----------------------------------------------------------------------
// Read ports.
// ----------------------------------------------------------------------

always_comb
begin
        o_rd_data_0 = idx_live(i_rd_idx_0) ? regs[i_rd_idx_0] : 32'd0;
        o_rd_data_1 = idx_live(i_rd_idx_1) ? regs[i_rd_idx_1] : 32'd0;
end

endmodule

//--- src/wb_commit.sv
// Retirement and exception entry for the writeback stage.
// Picks the register writes, keeps the CPSR and raises the writeback redirect.

`timescale 1ns/10ps

`include "cpu_defines.svh"

module wb_commit
        import cpu_arch_pkg::*;
        import reg_map_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_reset,

        input  logic            i_valid,
        input  logic            i_mem_load,
        input  phy_idx_t        i_wr_index,
        input  phy_idx_t        i_wr_index_1,
        input  logic [31:0]     i_wr_data,
        input  logic [31:0]     i_wr_data_1,
        input  logic [31:0]     i_pc_plus_8,
        input  cpsr_t           i_flags,

        input  logic            i_data_abt,
        input  logic            i_fiq,
        input  logic            i_irq,
        input  logic            i_instr_abt,
        input  logic            i_swi,
        input  logic            i_und,

        output logic            o_wen,
        output phy_idx_t        o_wr_idx_a,
        output phy_idx_t        o_wr_idx_b,
        output logic [31:0]     o_wr_data_a,
        output logic [31:0]     o_wr_data_b,

        output cpsr_t           o_cpsr,
        output logic            o_clear,
        output logic            o_redirect,
        output logic [31:0]     o_target
);

retire_kind_e   kind;
cpsr_t          cpsr_ff;
cpsr_t          cpsr_nxt;
phy_idx_t       lr_idx;
phy_idx_t       spsr_idx;
cpu_mode_e      exc_mode;
logic [31:0]    exc_vector;
logic           load_to_pc;

assign load_to_pc = i_mem_load && (i_wr_index_1 == `ARCH_PC);
assign o_cpsr     = cpsr_ff;
assign o_clear    = o_redirect;

// ----------------------------------------------------------------------
// Event ranking.
// ----------------------------------------------------------------------

always_comb
begin
        if (i_data_abt)
                kind = RET_DABT;
        else if (i_fiq)
                kind = RET_FIQ;
        else if (i_irq)
                kind = RET_IRQ;
        else if (i_instr_abt)
                kind = RET_PABT;
        else if (i_swi)
                kind = RET_SWI;
        else if (i_und)
                kind = RET_UND;
        else if (i_valid)
                kind = RET_RETIRE;
        else
                kind = RET_NONE;
end

// Banked registers, target mode and vector of each exception.
always_comb
begin
        case (kind)
        RET_DABT: begin lr_idx = `PHY_ABT_R14; spsr_idx = `PHY_ABT_SPSR;
                        exc_mode = MODE_ABT; exc_vector = `DABT_VECTOR; end
        RET_FIQ:  begin lr_idx = `PHY_FIQ_R14; spsr_idx = `PHY_FIQ_SPSR;
                        exc_mode = MODE_FIQ; exc_vector = `FIQ_VECTOR; end
        RET_IRQ:  begin lr_idx = `PHY_IRQ_R14; spsr_idx = `PHY_IRQ_SPSR;
                        exc_mode = MODE_IRQ; exc_vector = `IRQ_VECTOR; end
        RET_PABT: begin lr_idx = `PHY_ABT_R14; spsr_idx = `PHY_ABT_SPSR;
                        exc_mode = MODE_ABT; exc_vector = `PABT_VECTOR; end
        RET_SWI:  begin lr_idx = `PHY_SVC_R14; spsr_idx = `PHY_SVC_SPSR;
                        exc_mode = MODE_SVC; exc_vector = `SWI_VECTOR; end
        RET_UND:  begin lr_idx = `PHY_UND_R14; spsr_idx = `PHY_UND_SPSR;
                        exc_mode = MODE_UND; exc_vector = `UND_VECTOR; end
        default:  begin lr_idx = `PHY_RAZ_REG; spsr_idx = `PHY_RAZ_REG;
                        exc_mode = MODE_SVC; exc_vector = `RESET_VECTOR; end
        endcase
end

// ----------------------------------------------------------------------
// Register writes, CPSR update and redirect.
// ----------------------------------------------------------------------

always_comb
begin
        o_wen       = 1'b0;
        o_wr_idx_a  = `PHY_RAZ_REG;
        o_wr_idx_b  = `PHY_RAZ_REG;
        o_wr_data_a = 32'd0;
        o_wr_data_b = 32'd0;
        cpsr_nxt    = cpsr_ff;
        o_redirect  = 1'b0;
        o_target    = exc_vector;

        if (kind == RET_RETIRE)
        begin
                o_wen       = 1'b1;
                o_wr_idx_a  = i_wr_index;
                o_wr_data_a = i_wr_data;
                o_wr_idx_b  = i_mem_load ? i_wr_index_1 : `PHY_RAZ_REG;
                o_wr_data_b = i_wr_data_1;
                cpsr_nxt    = i_flags;

                // A load into R15 restarts fetch at the loaded address.
                if (load_to_pc)
                begin
                        o_redirect = 1'b1;
                        o_target   = i_wr_data_1;
                end
        end
        else if (kind != RET_NONE)
        begin
                // Save return address and old CPSR in the new mode's bank.
                o_wen       = 1'b1;
                o_wr_idx_a  = lr_idx;
                o_wr_data_a = (kind == RET_DABT) ? i_pc_plus_8 : i_wr_data;
                o_wr_idx_b  = spsr_idx;
                o_wr_data_b = cpsr_ff.raw;

                cpsr_nxt.fld.mode = exc_mode;
                cpsr_nxt.fld.i    = 1'b1;
                if (kind == RET_FIQ)
                        cpsr_nxt.fld.f = 1'b1;
                o_redirect        = 1'b1;
        end
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                cpsr_ff.raw <= `CPSR_INIT;
        end
        else
        begin
                cpsr_ff <= cpsr_nxt;
        end
end

endmodule

//--- src/pc_sequencer.sv
// Fetch PC register. Takes redirects by priority, freezes on stall and
// keeps a redirect that arrives during a stall until the stall ends.

`timescale 1ns/10ps

`include "cpu_defines.svh"

module pc_sequencer
(
        input  logic            i_clk,
        input  logic            i_reset,

        input  logic            i_stall,

        input  logic            i_wb_redirect,
        input  logic [31:0]     i_wb_target,
        input  logic            i_alu_clear,
        input  logic [31:0]     i_alu_pc,
        input  logic            i_decode_clear,
        input  logic [31:0]     i_decode_pc,

        output logic [31:0]     o_fetch_pc,
        output logic            o_fetch_stb,
        output logic            o_shelve
);

logic [31:0]    pc_ff, pc_nxt;
logic           stb_ff, stb_nxt;
logic           shelve_ff, shelve_nxt;
logic [31:0]    shelve_pc_ff, shelve_pc_nxt;
logic           redirect;
logic [31:0]    target;

assign o_fetch_pc  = pc_ff;
assign o_fetch_stb = stb_ff;
assign o_shelve    = shelve_ff;

// Writeback first, then ALU, then decode.
always_comb
begin
        redirect = i_wb_redirect | i_alu_clear | i_decode_clear;
        if (i_wb_redirect)
                target = i_wb_target;
        else if (i_alu_clear)
                target = i_alu_pc;
        else
                target = i_decode_pc;
end

// ----------------------------------------------------------------------
// Next PC.
// ----------------------------------------------------------------------

always_comb
begin
        pc_nxt        = pc_ff;
        stb_nxt       = 1'b1;
        shelve_nxt    = shelve_ff;
        shelve_pc_nxt = shelve_pc_ff;

        if (i_stall)
        begin
                // Hold fetch; a newer redirect replaces any saved one.
                stb_nxt = 1'b0;
                if (redirect)
                begin
                        shelve_nxt    = 1'b1;
                        shelve_pc_nxt = target;
                end
        end
        else if (redirect)
        begin
                pc_nxt     = target;
                shelve_nxt = 1'b0;
        end
        else if (shelve_ff)
        begin
                pc_nxt     = shelve_pc_ff;
                shelve_nxt = 1'b0;
        end
        else
        begin
                pc_nxt = pc_ff + `PC_STEP;
        end
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                pc_ff     <= `RESET_VECTOR;
                stb_ff    <= 1'b1;
                shelve_ff <= 1'b0;
        end
        else
        begin
                pc_ff     <= pc_nxt;
                stb_ff    <= stb_nxt;
                shelve_ff <= shelve_nxt;
        end
end

always_ff @(posedge i_clk)
begin
        shelve_pc_ff <= shelve_pc_nxt;
end

endmodule

//--- src/wb_top.sv
// Writeback stage top level. Joins the commit logic, the fetch PC
// sequencer and the physical register file.

`timescale 1ns/10ps

module wb_top
        import cpu_arch_pkg::*;
        import reg_map_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_reset,

        // Retiring instruction.
        input  logic            i_valid,
        input  logic            i_mem_load,
        input  phy_idx_t        i_wr_index,
        input  phy_idx_t        i_wr_index_1,
        input  logic [31:0]     i_wr_data,
        input  logic [31:0]     i_wr_data_1,
        input  logic [31:0]     i_pc_plus_8,
        input  cpsr_t           i_flags,

        // Exception requests.
        input  logic            i_data_abt,
        input  logic            i_fiq,
        input  logic            i_irq,
        input  logic            i_instr_abt,
        input  logic            i_swi,
        input  logic            i_und,

        // Fetch control from the rest of the pipeline.
        input  logic            i_stall,
        input  logic            i_alu_clear,
        input  logic [31:0]     i_alu_pc,
        input  logic            i_decode_clear,
        input  logic [31:0]     i_decode_pc,

        input  phy_idx_t        i_rd_idx_0,
        input  phy_idx_t        i_rd_idx_1,
        output logic [31:0]     o_rd_data_0,
        output logic [31:0]     o_rd_data_1,

        output cpsr_t           o_cpsr,
        output logic            o_clear_from_writeback,
        output logic [31:0]     o_fetch_pc,
        output logic            o_fetch_stb,
        output logic            o_shelve
);

// ----------------------------------------------------------------------
// Internal connections.
// ----------------------------------------------------------------------

logic           wen;
phy_idx_t       wr_idx_a;
phy_idx_t       wr_idx_b;
logic [31:0]    wr_data_a;
logic [31:0]    wr_data_b;
logic           wb_redirect;
logic [31:0]    wb_target;

wb_commit u_commit (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_valid        (i_valid),
        .i_mem_load     (i_mem_load),
        .i_wr_index     (i_wr_index),
        .i_wr_index_1   (i_wr_index_1),
        .i_wr_data      (i_wr_data),
        .i_wr_data_1    (i_wr_data_1),
        .i_pc_plus_8    (i_pc_plus_8),
        .i_flags        (i_flags),
        .i_data_abt     (i_data_abt),
        .i_fiq          (i_fiq),
        .i_irq          (i_irq),
        .i_instr_abt    (i_instr_abt),
        .i_swi          (i_swi),
        .i_und          (i_und),
        .o_wen          (wen),
        .o_wr_idx_a     (wr_idx_a),
        .o_wr_idx_b     (wr_idx_b),
        .o_wr_data_a    (wr_data_a),
        .o_wr_data_b    (wr_data_b),
        .o_cpsr         (o_cpsr),
        .o_clear        (o_clear_from_writeback),
        .o_redirect     (wb_redirect),
        .o_target       (wb_target)
);

pc_sequencer u_pc_seq (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_stall        (i_stall),
        .i_wb_redirect  (wb_redirect),
        .i_wb_target    (wb_target),
        .i_alu_clear    (i_alu_clear),
        .i_alu_pc       (i_alu_pc),
        .i_decode_clear (i_decode_clear),
        .i_decode_pc    (i_decode_pc),
        .o_fetch_pc     (o_fetch_pc),
        .o_fetch_stb    (o_fetch_stb),
        .o_shelve       (o_shelve)
);

reg_file u_rf (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_wen          (wen),
        .i_wr_idx_a     (wr_idx_a),
        .i_wr_idx_b     (wr_idx_b),
        .i_wr_data_a    (wr_data_a),
        .i_wr_data_b    (wr_data_b),
        .i_rd_idx_0     (i_rd_idx_0),
        .i_rd_idx_1     (i_rd_idx_1),
        .o_rd_data_0    (o_rd_data_0),
        .o_rd_data_1    (o_rd_data_1)
);

endmodule

//--- sim/wb_chk.sv
// Concurrent checks on the writeback top level, bound into wb_top.
// Fetch strobe, clear source, exception mode and shelve behavior.

`timescale 1ns/10ps

module wb_chk
        import cpu_arch_pkg::*;
(
        input  logic            i_clk,
        input  logic            i_reset,
        input  logic            i_valid,
        input  logic            i_data_abt,
        input  logic            i_fiq,
        input  logic            i_irq,
        input  logic            i_instr_abt,
        input  logic            i_swi,
        input  logic            i_und,
        input  logic            i_stall,
        input  cpsr_t           o_cpsr,
        input  logic            o_clear_from_writeback,
        input  logic            o_fetch_stb,
        input  logic            o_shelve
);

logic any_exc;

assign any_exc = i_data_abt | i_fiq | i_irq | i_instr_abt | i_swi | i_und;

// No fetch in the cycle after a stalled edge.
a_stall_no_stb: assert property (@(posedge i_clk) disable iff (i_reset)
        $past(i_stall) |-> !o_fetch_stb)
        else $error("fetch strobe high after a stalled edge");

a_clear_source: assert property (@(posedge i_clk) disable iff (i_reset)
        o_clear_from_writeback |-> (any_exc || i_valid))
        else $error("clear without exception or retirement");

// ----------------------------------------------------------------------
// Mode after exception entry.
// ----------------------------------------------------------------------

a_dabt_mode: assert property (@(posedge i_clk) disable iff (i_reset)
        i_data_abt |=> o_cpsr.fld.mode == MODE_ABT)
        else $error("mode after data abort is not ABT");

a_fiq_mode: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_fiq && !i_data_abt) |=> o_cpsr.fld.mode == MODE_FIQ)
        else $error("mode after FIQ is not FIQ");

a_irq_mode: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_irq && !(i_data_abt | i_fiq)) |=> o_cpsr.fld.mode == MODE_IRQ)
        else $error("mode after IRQ is not IRQ");

a_pabt_mode: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_instr_abt && !(i_data_abt | i_fiq | i_irq))
        |=> o_cpsr.fld.mode == MODE_ABT)
        else $error("mode after instruction abort is not ABT");

a_swi_mode: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_swi && !(i_data_abt | i_fiq | i_irq | i_instr_abt))
        |=> o_cpsr.fld.mode == MODE_SVC)
        else $error("mode after SWI is not SVC");

a_und_mode: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_und && !(i_data_abt | i_fiq | i_irq | i_instr_abt | i_swi))
        |=> o_cpsr.fld.mode == MODE_UND)
        else $error("mode after undefined instruction is not UND");

a_shelve_rise: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(o_shelve) |-> $past(i_stall))
        else $error("shelve rose without a stall");

endmodule

bind wb_top wb_chk u_chk (
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_valid                (i_valid),
        .i_data_abt             (i_data_abt),
        .i_fiq                  (i_fiq),
        .i_irq                  (i_irq),
        .i_instr_abt            (i_instr_abt),
        .i_swi                  (i_swi),
        .i_und                  (i_und),
        .i_stall                (i_stall),
        .o_cpsr                 (o_cpsr),
        .o_clear_from_writeback (o_clear_from_writeback),
        .o_fetch_stb            (o_fetch_stb),
        .o_shelve               (o_shelve)
);

//--- sim/wb_tb.sv
// Testbench for the writeback stage. Reads one step per line from the
// case file, drives the DUT on the rising edge and checks at mid-cycle.

`timescale 1ns/10ps

`include "cpu_defines.svh"

module wb_tb
        import cpu_arch_pkg::*;
        import reg_map_pkg::*;
;

localparam int NCOL        = 23;
localparam int MAX_CYCLES  = 2000;

logic           i_clk;
logic           i_reset;
logic           i_valid;
logic           i_mem_load;
phy_idx_t       i_wr_index;
phy_idx_t       i_wr_index_1;
logic [31:0]    i_wr_data;
logic [31:0]    i_wr_data_1;
logic [31:0]    i_pc_plus_8;
cpsr_t          i_flags;
logic           i_data_abt;
logic           i_fiq;
logic           i_irq;
logic           i_instr_abt;
logic           i_swi;
logic           i_und;
logic           i_stall;
logic           i_alu_clear;
logic [31:0]    i_alu_pc;
logic           i_decode_clear;
logic [31:0]    i_decode_pc;
phy_idx_t       i_rd_idx_0;
phy_idx_t       i_rd_idx_1;
logic [31:0]    o_rd_data_0;
logic [31:0]    o_rd_data_1;
cpsr_t          o_cpsr;
logic           o_clear_from_writeback;
logic [31:0]    o_fetch_pc;
logic           o_fetch_stb;
logic           o_shelve;

logic [31:0]    col [NCOL];

wb_top i_dut (.*);

always #50 i_clk = ~i_clk;

// ----------------------------------------------------------------------
// Failure reporting and compare tasks.
// ----------------------------------------------------------------------

task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
endtask

task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
                fail_run($sformatf("FAILED at %0t: %s expected %h got %h",
                        $time, name, exp, act));
endtask

task automatic check_cpsr(input string name, input cpsr_t exp, input cpsr_t act);
        if (act.raw !== exp.raw)
                fail_run($sformatf("FAILED at %0t: %s expected %h got %h",
                        $time, name, exp.raw, act.raw));
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
                fail_run($sformatf("FAILED at %0t: %s expected %b got %b",
                        $time, name, exp, act));
endtask

// Don't-care data is filled with random values.
task automatic drive_step();
        i_valid        <= col[0][0];
        i_mem_load     <= col[1][0];
        i_wr_index     <= col[2][5:0];
        i_wr_index_1   <= col[3][5:0];
        i_wr_data      <= col[4];
        i_wr_data_1    <= col[1][0] ? col[5] : $urandom;
        i_pc_plus_8    <= col[8][5] ? col[6] : $urandom;
        i_flags        <= col[7];
        i_data_abt     <= col[8][5];
        i_fiq          <= col[8][4];
        i_irq          <= col[8][3];
        i_instr_abt    <= col[8][2];
        i_swi          <= col[8][1];
        i_und          <= col[8][0];
        i_stall        <= col[9][0];
        i_alu_clear    <= col[10][0];
        i_alu_pc       <= col[10][0] ? col[11] : $urandom;
        i_decode_clear <= col[12][0];
        i_decode_pc    <= col[12][0] ? col[13] : $urandom;
        i_rd_idx_0     <= col[14][5:0];
        i_rd_idx_1     <= col[15][5:0];
endtask

task automatic check_step();
        check_word("o_rd_data_0", col[16], o_rd_data_0);
        check_word("o_rd_data_1", col[17], o_rd_data_1);
        check_cpsr("o_cpsr", col[18], o_cpsr);
        check_word("o_fetch_pc", col[19], o_fetch_pc);
        check_bit("o_fetch_stb", col[20][0], o_fetch_stb);
        check_bit("o_shelve", col[21][0], o_shelve);
        check_bit("o_clear_from_writeback", col[22][0], o_clear_from_writeback);
endtask

// Overall bound on the run.
initial
begin
        int cyc;
        for (cyc = 0; cyc < MAX_CYCLES; cyc++)
                @(posedge i_clk);
        fail_run("Timeout: the run did not finish within the cycle limit.");
end

// ----------------------------------------------------------------------
// Main sequence.
// ----------------------------------------------------------------------

initial
begin
        int     fd;
        int     n;
        int     steps;
        int     wait_cyc;
        string  line;

        void'($urandom(32'h7704d0ce));
        i_clk = 1'b0;
        i_reset = 1'b1;
        for (n = 0; n < NCOL; n++)
                col[n] = 32'd0;
        col[14] = {26'd0, `PHY_RAZ_REG};
        col[15] = {26'd0, `PHY_RAZ_REG};
        col[7] = `CPSR_INIT;
        drive_step();
        steps = 0;

        fd = $fopen("sim/wb_cases.txt", "r");
        if (fd == 0)
                fail_run("Cannot open the case file sim/wb_cases.txt.");

        repeat (4) @(posedge i_clk);
        i_reset <= 1'b0;

        // Fetch must come out of reset at the reset vector.
        wait_cyc = 0;
        @(negedge i_clk);
        while (!(o_fetch_stb === 1'b1 && o_fetch_pc === `RESET_VECTOR))
        begin
                wait_cyc++;
                if (wait_cyc > 10)
                        fail_run("Timeout waiting for fetch to leave reset.");
                @(negedge i_clk);
        end

        while (!$feof(fd))
        begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n")
                        continue;
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                        col[8], col[9], col[10], col[11], col[12], col[13], col[14],
                        col[15], col[16], col[17], col[18], col[19], col[20], col[21],
                        col[22]);
                if (n != NCOL)
                        fail_run($sformatf("Malformed case line: %s", line));
                @(posedge i_clk);
                drive_step();
                @(negedge i_clk);
                check_step();
                steps++;
        end
        $fclose(fd);

        if (steps == 0)
        begin
                fail_run("The case file held no steps.");
        end
        else
        begin
                $display("Simulation finished: PASS");
                $finish;
        end
end

endmodule

//--- sim/wb_cases.txt
# v ml widx widx1 wdata wdata1 pc8 flags exc stall aclr apc dclr dpc rd0 rd1 (all hex)
# exp: rd0 rd1 cpsr fetch_pc stb shelve clear; exc bits dabt fiq irq pabt swi und
1 1 01 02 11111111 22222222 0 200000D3 00 0 0 0 0 0 2d 2d 00000000 00000000 000000D3 00000004 1 0 0
1 1 03 03 AAAA0003 BBBB0003 0 200000D3 00 0 0 0 0 0 01 02 11111111 22222222 200000D3 00000008 1 0 0
1 0 2d 04 DEADBEEF CAFEF00D 0 8000001F 00 0 0 0 0 0 03 2d BBBB0003 00000000 200000D3 0000000C 1 0 0
0 0 00 00 00001004 00000000 0 00000000 02 0 0 0 0 0 2d 2d 00000000 00000000 8000001F 00000010 1 0 1
0 0 00 00 00000000 00000000 0 00000000 00 0 0 0 0 0 14 15 00001004 8000001F 80000093 00000008 1 0 0
0 0 00 00 00002000 00000000 0 00000000 10 0 0 0 0 0 2d 2d 00000000 00000000 80000093 0000000C 1 0 1
0 0 00 00 00003333 00000000 00003008 00000000 2A 0 0 0 0 0 10 11 00002000 80000093 800000D1 0000001C 1 0 1
0 0 00 00 00000000 00000000 0 00000000 00 0 0 0 0 0 16 17 00003008 800000D1 800000D7 00000010 1 0 0
0 0 00 00 00004444 00000000 0 00000000 0D 0 0 0 0 0 2d 2d 00000000 00000000 800000D7 00000014 1 0 1
0 0 00 00 00005555 00000000 0 00000000 05 0 0 0 0 0 12 13 00004444 800000D7 800000D2 00000018 1 0 1
0 0 00 00 00006666 00000000 0 00000000 01 0 0 0 0 0 16 17 00005555 800000D2 800000D7 0000000C 1 0 1
1 1 00 0f 00000077 00000400 0 6000001F 00 0 0 0 0 0 18 19 00006666 800000D7 800000DB 00000004 1 0 1
0 0 00 00 00000000 00000000 0 00000000 00 0 0 0 0 0 00 0f 00000077 00000400 6000001F 00000400 1 0 0
0 0 00 00 00000000 00000000 0 00000000 00 0 1 00000800 1 00000900 2d 2d 00000000 00000000 6000001F 00000404 1 0 0
0 0 00 00 00000000 00000000 0 00000000 00 0 0 0 1 00000A00 2d 2d 00000000 00000000 6000001F 00000800 1 0 0
0 0 00 00 00000000 00000000 0 00000000 00 1 0 0 0 0 2d 2d 00000000 00000000 6000001F 00000A00 1 0 0
0 0 00 00 00000000 00000000 0 00000000 00 1 1 00000C00 0 0 2d 2d 00000000 00000000 6000001F 00000A00 0 0 0
0 0 00 00 00000000 00000000 0 00000000 00 1 0 0 0 0 2d 2d 00000000 00000000 6000001F 00000A00 0 1 0
0 0 00 00 00000000 00000000 0 00000000 00 0 0 0 0 0 2d 2d 00000000 00000000 6000001F 00000A00 0 1 0
0 0 00 00 00000000 00000000 0 00000000 00 0 0 0 0 0 2d 2d 00000000 00000000 6000001F 00000C00 1 0 0
0 0 00 00 00000000 00000000 0 00000000 00 1 0 0 1 00000E00 2d 2d 00000000 00000000 6000001F 00000C04 1 0 0
0 0 00 00 00000000 00000000 0 00000000 00 0 1 00001000 0 0 2d 2d 00000000 00000000 6000001F 00000C04 0 1 0
0 0 00 00 00000000 00000000 0 00000000 00 0 0 0 0 0 2d 2d 00000000 00000000 6000001F 00001000 1 0 0
0 0 00 00 00000000 00000000 0 00000000 00 0 0 0 0 0 2d 2d 00000000 00000000 6000001F 00001004 1 0 0

//--- src.f
+incdir+src
src/cpu_arch_pkg.sv
src/reg_map_pkg.sv
src/reg_file.sv
src/wb_commit.sv
src/pc_sequencer.sv
src/wb_top.sv
sim/wb_chk.sv
sim/wb_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the writeback testbench with Verilator.
verilator --binary --timing --assert -f src.f --top-module wb_tb -o wb_sim \
        && ./obj_dir/wb_sim \
        || exit 1
